// File: verilog.f
+incdir+hw
hw/mem_pkg.sv
hw/memory_controller.sv
hw/boot_rom.sv
hw/ram_model.sv
hw/csr_mem.sv
hw/mem_subsystem.sv
tb/mem_subsystem_asserts.sv
tb/mem_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the memory bus testbench
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/mem_subsystem_tb.sv
/* testbench for the memory bus: clock, reset, stimulus, reference model,
   compare tasks, timeout and the bind of the protocol assertions */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem_tb;

  localparam time DRIVE_DLY = 1;                 // inputs move this long after posedge
  localparam int  N_ROM = 40;
  localparam int  N_RAM = 20;
  // reset, ROM reads, four RAM accesses per address, register tests
  localparam int  EST_CYCLES = 10 + N_ROM * (`ROM_WAIT + 2) +
                               4 * N_RAM * (`RAM_WAIT + 2) + 100;
  localparam int  MAX_CYCLES = 3 * EST_CYCLES;

  logic clock, rst_n;
  logic mem_rd_en, mem_wr_en;
  mem_pkg::mem_strb_t mem_byte_en;
  mem_pkg::mem_data_t wr_data, rd_data;
  mem_pkg::mem_addr_t mem_addr;
  logic mem_busy, timer_irq, soft_irq;

  logic [15:0]        lfsr_state = 16'd34961;
  mem_pkg::mem_data_t shadow [0:`RAM_WORDS-1];   // RAM as the processor should see it
  mem_pkg::mem_addr_t ram_addrs [$];
  mem_pkg::mem_data_t exp_data, t1, t2;
  mem_pkg::mem_addr_t addr;
  mem_pkg::mem_strb_t strb;
  logic               exp_pending = 1'b0;
  int                 cycles = 0;
  int                 n;

  mem_subsystem UUT (.*);

  bind memory_controller mem_subsystem_asserts u_asserts (
    .clock(mem_subsystem_tb.clock), .rst_n(mem_subsystem_tb.rst_n),
    .mem_rd_en(mem_rd_en), .mem_wr_en(mem_wr_en), .mem_busy(mem_busy),
    .mem_addr(mem_addr),
    .inst_cache_enable(inst_cache_enable), .ram_output_enable(ram_output_enable),
    .ram_write_enable(ram_write_enable), .csr_mem_rd_en(csr_mem_rd_en),
    .csr_mem_wr_en(csr_mem_wr_en)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic mem_pkg::mem_data_t rand_bits(input int nbits);
    mem_pkg::mem_data_t r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    end
    return r;
  endfunction

  // ROM word: inverted word index on top, word index below
  function automatic mem_pkg::mem_data_t rom_word(input mem_pkg::mem_addr_t a);
    logic [31:0] idx;
    idx = 32'((a - `ROM_BASE) / `MEM_BYTES);     // word index within the ROM
    return (64'(~idx) << 32) | 64'(idx);
  endfunction

  function automatic mem_pkg::mem_data_t merge_bytes(input mem_pkg::mem_data_t old_w,
      input mem_pkg::mem_data_t new_w, input mem_pkg::mem_strb_t be);
    mem_pkg::mem_data_t m;
    m = old_w;
    for (int b = 0; b < `MEM_BYTES; b++) begin
      if (be[b]) m[8*b +: 8] = new_w[8*b +: 8];
    end
    return m;
  endfunction

  function automatic int shadow_idx(input mem_pkg::mem_addr_t a);
    return int'(((a - `RAM_BASE) >> 3) % `RAM_WORDS);   // RAM mirrors above its depth
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input mem_pkg::mem_data_t got,
                            input mem_pkg::mem_data_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // hold the request until busy is seen low, then let the completion edge pass
  task automatic finish_access(output mem_pkg::mem_data_t data);
    @(negedge clock);
    while (mem_busy) @(negedge clock);
    data = rd_data;
    @(posedge clock);
    #DRIVE_DLY;
    mem_rd_en = 1'b0;
    mem_wr_en = 1'b0;
  endtask

  task automatic bus_read(input mem_pkg::mem_addr_t a, output mem_pkg::mem_data_t data);
    mem_addr  = a;
    mem_rd_en = 1'b1;
    finish_access(data);
  endtask

  task automatic bus_write(input mem_pkg::mem_addr_t a, input mem_pkg::mem_data_t d,
                           input mem_pkg::mem_strb_t be);
    mem_pkg::mem_data_t unused;
    mem_addr    = a;
    wr_data     = d;
    mem_byte_en = be;
    mem_wr_en   = 1'b1;
    finish_access(unused);
  endtask

  task automatic read_expect(input mem_pkg::mem_addr_t a, input mem_pkg::mem_data_t exp);
    mem_pkg::mem_data_t unused;
    exp_data    = exp;
    exp_pending = 1'b1;
    bus_read(a, unused);
  endtask

  // compares the expected word in the completion cycle of a checked read
  always @(negedge clock) begin
    if (rst_n && mem_rd_en && !mem_busy && exp_pending) begin
      check_data("rd_data", rd_data, exp_data);
      exp_pending = 1'b0;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) fail_stop("timeout: the test sequence did not finish");
  end

  initial begin
    rst_n = 1'b0;
    mem_rd_en = 1'b0;
    mem_wr_en = 1'b0;
    mem_byte_en = '0;
    wr_data = '0;
    mem_addr = '0;
    repeat (10) @(posedge clock);
    #DRIVE_DLY;
    rst_n = 1'b1;
    check_flag("mem_busy", mem_busy, 1'b0);
    check_flag("soft_irq", soft_irq, 1'b0);

    for (int i = 0; i < N_ROM; i++) begin          // ROM pattern
      addr = `ROM_BASE + (rand_bits(21) << 3);
      read_expect(addr, rom_word(addr));
    end

    for (int i = 0; i < N_RAM; i++) begin          // fill whole words first
      addr = `RAM_BASE + (rand_bits(23) << 3);
      ram_addrs.push_back(addr);
      wr_data = rand_bits(64);
      shadow[shadow_idx(addr)] = wr_data;
      bus_write(addr, wr_data, '1);
    end
    foreach (ram_addrs[i]) begin                   // then partial updates
      strb = mem_pkg::mem_strb_t'(rand_bits(8));
      wr_data = rand_bits(64);
      shadow[shadow_idx(ram_addrs[i])] = merge_bytes(shadow[shadow_idx(ram_addrs[i])],
                                                     wr_data, strb);
      bus_write(ram_addrs[i], wr_data, strb);
    end
    foreach (ram_addrs[i]) begin                   // direct and mirrored reads
      read_expect(ram_addrs[i], shadow[shadow_idx(ram_addrs[i])]);
      addr = ram_addrs[i] ^ 64'(`RAM_WORDS * 8);
      read_expect(addr, shadow[shadow_idx(addr)]);
    end

    wr_data = rand_bits(64);
    bus_write(`MTIMECMP_ADDR, wr_data, '1);
    read_expect(`MTIMECMP_ADDR, wr_data);
    bus_write(`MSIP_ADDR, 64'd1, '1);
    check_flag("soft_irq", soft_irq, 1'b1);
    bus_write(`MSIP_ADDR, 64'd0, '1);
    check_flag("soft_irq", soft_irq, 1'b0);

    bus_read(`MTIME_ADDR, t1);
    bus_read(`MTIME_ADDR, t2);
    check_flag("mtime advanced", t2 > t1, 1'b1);
    bus_write(`MTIMECMP_ADDR, t2 + 64'd20, '1);
    @(posedge clock);                              // timer_irq is one cycle behind
    #DRIVE_DLY;
    check_flag("timer_irq", timer_irq, 1'b0);
    for (n = 0; n < 40 && !timer_irq; n++) begin
      @(posedge clock);
      #DRIVE_DLY;
    end
    if (!timer_irq) fail_stop("timer interrupt did not rise within 40 cycles");

    mem_addr  = 64'h0000_0000_8000_0000;           // nothing mapped here
    mem_rd_en = 1'b1;
    @(negedge clock);
    check_flag("mem_busy", mem_busy, 1'b0);
    check_data("rd_data", rd_data, '0);
    @(posedge clock);
    #DRIVE_DLY;
    mem_rd_en = 1'b0;

    repeat (2) @(posedge clock);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/mem_subsystem_asserts.sv
/* bus protocol assertions, bound to the memory controller */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_subsystem_asserts (
  input logic               clock,
  input logic               rst_n,
  input logic               mem_rd_en,
  input logic               mem_wr_en,
  input logic               mem_busy,
  input mem_pkg::mem_addr_t mem_addr,
  input logic               inst_cache_enable,
  input logic               ram_output_enable,
  input logic               ram_write_enable,
  input logic               csr_mem_rd_en,
  input logic               csr_mem_wr_en
);

  one_enable: assert property (@(posedge clock) disable iff (!rst_n)
    !(mem_rd_en && mem_wr_en)) else $error("read and write enable both high");

  // each target only sees accesses that fall in its own part of the address map
  rom_gated: assert property (@(posedge clock) disable iff (!rst_n)
    inst_cache_enable |-> (mem_rd_en && (mem_addr inside {[`ROM_BASE:`ROM_TOP]})))
    else $error("ROM enabled outside its address window");

  ram_gated: assert property (@(posedge clock) disable iff (!rst_n)
    (ram_output_enable || ram_write_enable) |->
      (mem_addr inside {[`RAM_BASE:`RAM_TOP]}))
    else $error("RAM enabled outside its address window");

  csr_gated: assert property (@(posedge clock) disable iff (!rst_n)
    (csr_mem_rd_en || csr_mem_wr_en) |->
      (mem_addr inside {`MSIP_ADDR, `SSIP_ADDR,
                        [`MTIME_ADDR:`MTIME_ADDR + 64'd7],
                        [`MTIMECMP_ADDR:`MTIMECMP_ADDR + 64'd7]}))
    else $error("register block enabled outside its addresses");

  // a stalled request keeps its address until busy falls
  addr_hold: assert property (@(posedge clock) disable iff (!rst_n)
    ((mem_rd_en || mem_wr_en) && mem_busy) |=> $stable(mem_addr))
    else $error("address changed while the access was pending");

endmodule

`default_nettype wire

// File: hw/mem_subsystem.sv
/* memory bus top: controller plus boot ROM, RAM and machine registers */
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               mem_rd_en,
  input  logic               mem_wr_en,
  input  mem_pkg::mem_strb_t mem_byte_en,
  input  mem_pkg::mem_data_t wr_data,
  input  mem_pkg::mem_addr_t mem_addr,
  output mem_pkg::mem_data_t rd_data,
  output logic               mem_busy,
  output logic               timer_irq,
  output logic               soft_irq
);

  mem_pkg::mem_data_t inst_cache_data, ram_read_data, ram_write_data;
  mem_pkg::mem_data_t csr_mem_rd_data, csr_mem_wr_data;
  mem_pkg::mem_addr_t inst_cache_addr, ram_address;
  mem_pkg::mem_strb_t ram_byte_enable;
  mem_pkg::csr_addr_t csr_mem_addr;
  logic inst_cache_enable, inst_cache_busy;
  logic ram_chip_select, ram_output_enable, ram_write_enable, ram_busy;
  logic csr_mem_rd_en, csr_mem_wr_en, csr_mem_busy;

  memory_controller u_ctrl (
    .inst_cache_data, .inst_cache_busy, .inst_cache_enable, .inst_cache_addr,
    .ram_read_data, .ram_busy, .ram_address, .ram_write_data,
    .ram_output_enable, .ram_write_enable, .ram_chip_select, .ram_byte_enable,
    .csr_mem_busy, .csr_mem_rd_data, .csr_mem_wr_data,
    .csr_mem_rd_en, .csr_mem_wr_en, .csr_mem_addr,
    .mem_rd_en, .mem_wr_en, .mem_byte_en, .wr_data, .mem_addr,
    .rd_data, .mem_busy
  );

  boot_rom u_rom (
    .clock, .rst_n,
    .inst_cache_enable, .inst_cache_addr, .inst_cache_data, .inst_cache_busy
  );

  ram_model u_ram (
    .clock, .rst_n,
    .ram_chip_select, .ram_output_enable, .ram_write_enable, .ram_byte_enable,
    .ram_address, .ram_write_data, .ram_read_data, .ram_busy
  );

  csr_mem u_csr (
    .clock, .rst_n,
    .csr_mem_rd_en, .csr_mem_wr_en, .csr_mem_addr, .csr_mem_wr_data,
    .csr_mem_rd_data, .csr_mem_busy,
    .timer_irq, .soft_irq
  );

endmodule

`default_nettype wire

// File: hw/csr_mem.sv
/* memory-mapped machine registers msip, ssip, mtime, mtimecmp
   and the software and timer interrupts */
`timescale 1ns/1ps
`default_nettype none

module csr_mem (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               csr_mem_rd_en,
  input  logic               csr_mem_wr_en,
  input  mem_pkg::csr_addr_t csr_mem_addr,
  input  mem_pkg::mem_data_t csr_mem_wr_data,
  output mem_pkg::mem_data_t csr_mem_rd_data,
  output logic               csr_mem_busy,
  output logic               timer_irq,
  output logic               soft_irq
);

  mem_pkg::mem_data_t msip, ssip, mtime, mtimecmp;
  mem_pkg::mem_data_t sel_reg;
  mem_pkg::mem_data_t wr_merged;
  logic               upper;

  assign upper = csr_mem_addr[2];

  // upper-half write replaces bits 63:32 from the low lanes
  assign wr_merged = upper ? {csr_mem_wr_data[31:0], sel_reg[31:0]} : csr_mem_wr_data;

  always_comb begin
    case (csr_mem_addr[1:0])
      2'b00:   sel_reg = msip;
      2'b01:   sel_reg = ssip;
      2'b10:   sel_reg = mtime;
      default: sel_reg = mtimecmp;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      msip      <= '0;
      ssip      <= '0;
      mtime     <= '0;
      mtimecmp  <= '0;
      timer_irq <= 1'b0;
    end else begin
      if (csr_mem_wr_en && csr_mem_addr[1:0] == 2'b00) msip <= {63'b0, csr_mem_wr_data[0]};
      if (csr_mem_wr_en && csr_mem_addr[1:0] == 2'b01) ssip <= {63'b0, csr_mem_wr_data[0]};
      if (csr_mem_wr_en && csr_mem_addr[1:0] == 2'b11) mtimecmp <= wr_merged;
      if (csr_mem_wr_en && csr_mem_addr[1:0] == 2'b10) begin
        mtime <= wr_merged;                   // a write wins over the tick
      end else begin
        mtime <= mtime + 1'b1;
      end
      timer_irq <= (mtime >= mtimecmp);
    end
  end

  // upper half reads back in the low lanes
  assign csr_mem_rd_data = !csr_mem_rd_en ? '0 :
                           upper ? {32'b0, sel_reg[63:32]} : sel_reg;

  assign csr_mem_busy = 1'b0;                 // single-cycle target
  assign soft_irq     = msip[0];

endmodule

`default_nettype wire

// File: hw/ram_model.sv
/* byte-enabled RAM target with wait states, mirrored above its depth */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module ram_model (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               ram_chip_select,
  input  logic               ram_output_enable,
  input  logic               ram_write_enable,
  input  mem_pkg::mem_strb_t ram_byte_enable,
  input  mem_pkg::mem_addr_t ram_address,
  input  mem_pkg::mem_data_t ram_write_data,
  output mem_pkg::mem_data_t ram_read_data,
  output logic               ram_busy
);

  localparam int IDX_W = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(`RAM_WAIT + 1);

  mem_pkg::mem_data_t mem [0:`RAM_WORDS-1];
  logic [IDX_W-1:0]   word_idx;
  logic [CNT_W-1:0]   wait_cnt;
  logic               active;
  logic               done;

  assign word_idx = ram_address[IDX_W+2:3];   // upper address bits ignored
  assign active   = ram_chip_select & (ram_output_enable | ram_write_enable);
  assign done     = active & (wait_cnt == CNT_W'(`RAM_WAIT));
  assign ram_busy = active & ~done;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!active || done) begin
      wait_cnt <= '0;                         // ready for a back-to-back access
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // write lands on the completion edge, only enabled lanes change
  always_ff @(posedge clock) begin
    if (done && ram_write_enable) begin
      for (int b = 0; b < `MEM_BYTES; b++) begin
        if (ram_byte_enable[b]) begin
          mem[word_idx][8*b +: 8] <= ram_write_data[8*b +: 8];
        end
      end
    end
  end

  assign ram_read_data = ram_output_enable ? mem[word_idx] : '0;

endmodule

`default_nettype wire

// File: hw/boot_rom.sv
/* boot ROM target with index-derived contents and wait states */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module boot_rom (
  input  logic               clock,
  input  logic               rst_n,
  input  logic               inst_cache_enable,
  input  mem_pkg::mem_addr_t inst_cache_addr,
  output mem_pkg::mem_data_t inst_cache_data,
  output logic               inst_cache_busy
);

  localparam int CNT_W = $clog2(`ROM_WAIT + 1);

  logic [CNT_W-1:0] wait_cnt;
  logic [31:0]      word_idx;
  logic             done;

  assign word_idx = {11'b0, inst_cache_addr[23:3]};     // 8-byte words in 16 MiB
  assign done     = inst_cache_enable & (wait_cnt == CNT_W'(`ROM_WAIT));

  assign inst_cache_busy = inst_cache_enable & ~done;
  assign inst_cache_data = inst_cache_enable ? {~word_idx, word_idx} : '0;

  // counts busy cycles, cleared at completion so the next access waits again
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (!inst_cache_enable || done) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/memory_controller.sv
/* memory bus decode: target selects and enables, RAM rebasing,
   read data and busy return */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module memory_controller (
  // boot ROM
  input  mem_pkg::mem_data_t inst_cache_data,
  input  logic               inst_cache_busy,
  output logic               inst_cache_enable,
  output mem_pkg::mem_addr_t inst_cache_addr,

  // RAM
  input  mem_pkg::mem_data_t ram_read_data,
  input  logic               ram_busy,
  output mem_pkg::mem_addr_t ram_address,
  output mem_pkg::mem_data_t ram_write_data,
  output logic               ram_output_enable,
  output logic               ram_write_enable,
  output logic               ram_chip_select,
  output mem_pkg::mem_strb_t ram_byte_enable,

  // machine registers
  input  logic               csr_mem_busy,
  input  mem_pkg::mem_data_t csr_mem_rd_data,
  output mem_pkg::mem_data_t csr_mem_wr_data,
  output logic               csr_mem_rd_en,
  output logic               csr_mem_wr_en,
  output mem_pkg::csr_addr_t csr_mem_addr,

  // processor side
  input  logic               mem_rd_en,
  input  logic               mem_wr_en,
  input  mem_pkg::mem_strb_t mem_byte_en,
  input  mem_pkg::mem_data_t wr_data,
  input  mem_pkg::mem_addr_t mem_addr,
  output mem_pkg::mem_data_t rd_data,
  output logic               mem_busy
);

  mem_pkg::mem_addr_t rom_offset;
  mem_pkg::mem_addr_t ram_offset;
  logic rom_sel, ram_sel;
  logic msip_sel, ssip_sel, mtime_sel, mtimecmp_sel, csr_sel;
  logic [1:0] csr_code;

  // window checks on the offset, so a base other than zero works too
  assign rom_offset = mem_addr - `ROM_BASE;
  assign ram_offset = mem_addr - `RAM_BASE;
  assign rom_sel    = rom_offset <= (`ROM_TOP - `ROM_BASE);
  assign ram_sel    = ram_offset <= (`RAM_TOP - `RAM_BASE);

  assign msip_sel     = (mem_addr == `MSIP_ADDR);
  assign ssip_sel     = (mem_addr == `SSIP_ADDR);
  assign mtime_sel    = ({mem_addr[63:3], 3'b000} == `MTIME_ADDR);    // both halves
  assign mtimecmp_sel = ({mem_addr[63:3], 3'b000} == `MTIMECMP_ADDR);
  assign csr_sel      = msip_sel | ssip_sel | mtime_sel | mtimecmp_sel;

  // ROM is read only, a write there completes without effect
  assign inst_cache_enable = rom_sel & mem_rd_en;
  assign inst_cache_addr   = rom_offset;

  assign ram_chip_select   = ram_sel;
  assign ram_output_enable = ram_sel & mem_rd_en;
  assign ram_write_enable  = ram_sel & mem_wr_en;
  assign ram_byte_enable   = ram_sel ? mem_byte_en : '0;
  assign ram_address       = ram_offset;                  // RAM sees addresses from zero
  assign ram_write_data    = wr_data;

  assign csr_code = msip_sel  ? 2'b00 :
                    ssip_sel  ? 2'b01 :
                    mtime_sel ? 2'b10 : 2'b11;
  assign csr_mem_addr    = {mem_addr[2], csr_code};
  assign csr_mem_rd_en   = csr_sel & mem_rd_en;
  assign csr_mem_wr_en   = csr_sel & mem_wr_en;
  assign csr_mem_wr_data = wr_data;

  // result mux, unmapped addresses read zero and never stall
  assign rd_data = rom_sel ? inst_cache_data :
                   ram_sel ? ram_read_data :
                   csr_sel ? csr_mem_rd_data : '0;

  assign mem_busy = rom_sel ? inst_cache_busy :
                    ram_sel ? ram_busy :
                    csr_sel ? csr_mem_busy : 1'b0;

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
/* shared types for the memory bus: address, data, byte strobe, register select */
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

  // byte address as seen by the processor
  typedef logic [63:0] mem_addr_t;

  // one bus word, eight byte lanes
  typedef logic [8*`MEM_BYTES-1:0] mem_data_t;

  // byte enables, bit n covers data[8n+7:8n]
  typedef logic [`MEM_BYTES-1:0] mem_strb_t;

  // [1:0] msip/ssip/mtime/mtimecmp, [2] upper half of a 64-bit register
  typedef logic [2:0] csr_addr_t;

endpackage

`default_nettype wire

// File: hw/mem_config.svh
/* bus width, address map, wait states and RAM depth for the memory bus */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

`define MEM_BYTES 8                          // byte lanes on the data bus

`define ROM_BASE 64'h0000_0000_0000_0000     // 16 MiB boot ROM
`define ROM_TOP  64'h0000_0000_00FF_FFFF
`define RAM_BASE 64'h0000_0000_0100_0000     // 64 MiB RAM window
`define RAM_TOP  64'h0000_0000_04FF_FFFF

`define MSIP_ADDR     64'h0000_0000_FFFF_FFC0
`define SSIP_ADDR     64'h0000_0000_FFFF_FFD0
`define MTIME_ADDR    64'h0000_0000_FFFF_FFE0  // 8-byte aligned
`define MTIMECMP_ADDR 64'h0000_0000_FFFF_FFF0  // 8-byte aligned

`define ROM_WAIT  2                          // busy cycles per ROM access
`define RAM_WAIT  3                          // busy cycles per RAM access
`define RAM_WORDS 1024                       // physical depth, mirrored above
`endif
